// ==== verilog/udp_proto_pkg.sv ====
/*
 * UDP protocol field types for the echo engine
 * Response header record and payload beat record
 * Fixed TTL, default echo port and default local address
 */
package udp_proto_pkg;

    // Header fields
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  ip_ttl_t;

    // Payload stream is one byte per beat
    typedef logic [7:0]  payload_byte_t;

    // Outgoing header as queued in the header FIFO
    typedef struct packed {
        ip_addr_t    src_ip;
        ip_addr_t    dst_ip;
        udp_port_t   src_port;
        udp_port_t   dst_port;
        udp_len_t    length;
        ip_ttl_t     ttl;
        logic [15:0] checksum;
    } echo_hdr_t;

    // One payload beat with its framing bits
    typedef struct packed {
        payload_byte_t data;
        logic          last;
        logic          user;
    } payload_beat_t;

    localparam ip_ttl_t   ECHO_TTL          = 8'd64;
    localparam udp_port_t DEFAULT_ECHO_PORT = 16'd1234;

    // 192.168.1.128
    localparam ip_addr_t  DEFAULT_LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128};

endpackage

// ==== verilog/board_io_pkg.sv ====
/*
 * Board I/O types for the status display
 * Seven-segment pattern, green LED byte, digit count
 */
package board_io_pkg;

    // Segment a in bit 0 up to segment g in bit 6
    typedef logic [6:0] seg7_t;

    // Green LED bank
    typedef logic [7:0] led_byte_t;

    // One digit per nibble of an IPv4 address
    localparam int HEX_DIGITS = 8;

endpackage

// ==== verilog/hex_digit_decoder.sv ====
/*
 * Nibble to seven-segment decoder
 * Hexadecimal font, optional active-low output
 */
`timescale 1ns/1ps

module hex_digit_decoder #(
    parameter bit SEG_ACTIVE_LOW = 1'b1
) (
    input  logic [3:0]          nibble,
    output board_io_pkg::seg7_t seg
);

    import board_io_pkg::*;

    seg7_t font;

    // Patterns are active high, bit 0 is segment a
    always_comb begin
        case (nibble)
            4'h0: font = 7'h3f;
            4'h1: font = 7'h06;
            4'h2: font = 7'h5b;
            4'h3: font = 7'h4f;
            4'h4: font = 7'h66;
            4'h5: font = 7'h6d;
            4'h6: font = 7'h7d;
            4'h7: font = 7'h07;
            4'h8: font = 7'h7f;
            4'h9: font = 7'h6f;
            4'ha: font = 7'h77;
            4'hb: font = 7'h7c;
            4'hc: font = 7'h39;
            4'hd: font = 7'h5e;
            4'he: font = 7'h79;
            default: font = 7'h71;
        endcase
    end

    assign seg = SEG_ACTIVE_LOW ? ~font : font;

endmodule

// ==== verilog/frame_fifo.sv ====
/*
 * Synchronous valid/ready FIFO
 * Item type and depth set by parameters
 * Circular buffer with occupancy count
 */
`timescale 1ns/1ps

module frame_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  in_valid,
    output logic  in_ready,
    input  item_t in_item,
    output logic  out_valid,
    input  logic  out_ready,
    output item_t out_item
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Wrap at DEPTH so non power of two depths work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // Head of queue read straight from storage
    assign out_item = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= CNT_W'(DEPTH));

    // A stalled head must not change under a concurrent write
    hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_item));

endmodule

// ==== verilog/udp_port_filter.sv ====
/*
 * UDP port filter for the echo path
 * Idle/payload FSM with a keep or drop flag per frame
 * Builds the swapped response header and routes payload beats
 */
`timescale 1ns/1ps

module udp_port_filter #(
    parameter udp_proto_pkg::udp_port_t ECHO_PORT = udp_proto_pkg::DEFAULT_ECHO_PORT,
    parameter udp_proto_pkg::ip_addr_t  LOCAL_IP  = udp_proto_pkg::DEFAULT_LOCAL_IP
) (
    input  logic                         clk,
    input  logic                         rst,

    // Receive header
    input  logic                         rx_hdr_valid,
    output logic                         rx_hdr_ready,
    input  udp_proto_pkg::ip_addr_t      rx_src_ip,
    input  udp_proto_pkg::ip_addr_t      rx_dst_ip,
    input  udp_proto_pkg::udp_port_t     rx_src_port,
    input  udp_proto_pkg::udp_port_t     rx_dst_port,
    input  udp_proto_pkg::udp_len_t      rx_length,

    // Receive payload
    input  udp_proto_pkg::payload_byte_t rx_data,
    input  logic                         rx_valid,
    output logic                         rx_ready,
    input  logic                         rx_last,
    input  logic                         rx_user,

    // Into the header FIFO
    output logic                         hdr_push_valid,
    input  logic                         hdr_push_ready,
    output udp_proto_pkg::echo_hdr_t     hdr_push,

    // Into the payload FIFO
    output logic                         beat_push_valid,
    input  logic                         beat_push_ready,
    output udp_proto_pkg::payload_beat_t beat_push
);

    import udp_proto_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_PAYLOAD
    } state_t;

    state_t state_q;
    logic   keep_q;
    logic   port_match;
    logic   hdr_fire;
    logic   last_fire;

    assign port_match = (rx_dst_port == ECHO_PORT);

    // Matching frames also need room for their response header
    assign rx_hdr_ready   = (state_q == ST_IDLE) && (!port_match || hdr_push_ready);
    assign hdr_fire       = rx_hdr_valid && rx_hdr_ready;
    assign hdr_push_valid = (state_q == ST_IDLE) && rx_hdr_valid && port_match;

    // Addresses and ports swapped, length kept
    always_comb begin
        hdr_push.src_ip   = LOCAL_IP;
        hdr_push.dst_ip   = rx_src_ip;
        hdr_push.src_port = rx_dst_port;
        hdr_push.dst_port = rx_src_port;
        hdr_push.length   = rx_length;
        hdr_push.ttl      = ECHO_TTL;
        hdr_push.checksum = '0;
    end

    // Dropped frames are sunk at full rate
    assign rx_ready        = (state_q == ST_PAYLOAD) && (keep_q ? beat_push_ready : 1'b1);
    assign beat_push_valid = (state_q == ST_PAYLOAD) && keep_q && rx_valid;
    assign last_fire       = rx_valid && rx_ready && rx_last;

    always_comb begin
        beat_push.data = rx_data;
        beat_push.last = rx_last;
        beat_push.user = rx_user;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_IDLE;
            keep_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (hdr_fire) begin
                        keep_q  <= port_match;
                        state_q <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (last_fire) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Next header waits until the current frame has ended
    hdr_only_idle: assert property (@(posedge clk) disable iff (rst)
        hdr_fire |=> !rx_hdr_ready);

    drop_no_push: assert property (@(posedge clk) disable iff (rst)
        hdr_fire && !port_match |=> !beat_push_valid);

endmodule

// ==== verilog/echo_status_display.sv ====
/*
 * Status display for outgoing frames
 * First payload byte of each frame on the green LEDs
 * Destination IP latch driving eight hex digits
 */
`timescale 1ns/1ps

module echo_status_display #(
    parameter bit SEG_ACTIVE_LOW = 1'b1
) (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic                                                tx_hdr_fire,
    input  udp_proto_pkg::ip_addr_t                             tx_dst_ip,
    input  logic                                                beat_fire,
    input  udp_proto_pkg::payload_byte_t                        beat_data,
    input  logic                                                beat_last,
    output board_io_pkg::led_byte_t                             ledg,
    output board_io_pkg::seg7_t [board_io_pkg::HEX_DIGITS-1:0] hex
);

    import udp_proto_pkg::*;
    import board_io_pkg::*;

    logic     frame_start_q;
    ip_addr_t dst_ip_q;

    // Next beat opens a frame once the previous one closed
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_start_q <= 1'b1;
            ledg          <= '0;
        end else if (beat_fire) begin
            if (frame_start_q) begin
                ledg <= beat_data;
            end
            frame_start_q <= beat_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dst_ip_q <= '0;
        end else if (tx_hdr_fire) begin
            dst_ip_q <= tx_dst_ip;
        end
    end

    // Digit i shows nibble i of the address
    for (genvar i = 0; i < HEX_DIGITS; i++) begin : g_digit
        hex_digit_decoder #(
            .SEG_ACTIVE_LOW(SEG_ACTIVE_LOW)
        ) u_decoder (
            .nibble(dst_ip_q[4*i +: 4]),
            .seg   (hex[i])
        );
    end

endmodule

// ==== verilog/udp_echo_top.sv ====
/*
 * UDP echo engine top level
 * Port filter, header and payload FIFOs, status display
 * Unpacks queued records onto the transmit ports
 */
`timescale 1ns/1ps

module udp_echo_top #(
    parameter udp_proto_pkg::udp_port_t ECHO_PORT      = udp_proto_pkg::DEFAULT_ECHO_PORT,
    parameter udp_proto_pkg::ip_addr_t  LOCAL_IP       = udp_proto_pkg::DEFAULT_LOCAL_IP,
    parameter int                       HDR_DEPTH      = 8,
    parameter int                       PAYLOAD_DEPTH  = 64,
    parameter bit                       SEG_ACTIVE_LOW = 1'b1
) (
    input  logic                                                clk,
    input  logic                                                rst,

    // Receive header and payload
    input  logic                                                rx_hdr_valid,
    output logic                                                rx_hdr_ready,
    input  udp_proto_pkg::ip_addr_t                             rx_src_ip,
    input  udp_proto_pkg::ip_addr_t                             rx_dst_ip,
    input  udp_proto_pkg::udp_port_t                            rx_src_port,
    input  udp_proto_pkg::udp_port_t                            rx_dst_port,
    input  udp_proto_pkg::udp_len_t                             rx_length,
    input  udp_proto_pkg::payload_byte_t                        rx_data,
    input  logic                                                rx_valid,
    output logic                                                rx_ready,
    input  logic                                                rx_last,
    input  logic                                                rx_user,

    // Transmit header and payload
    output logic                                                tx_hdr_valid,
    input  logic                                                tx_hdr_ready,
    output udp_proto_pkg::ip_addr_t                             tx_src_ip,
    output udp_proto_pkg::ip_addr_t                             tx_dst_ip,
    output udp_proto_pkg::udp_port_t                            tx_src_port,
    output udp_proto_pkg::udp_port_t                            tx_dst_port,
    output udp_proto_pkg::udp_len_t                             tx_length,
    output udp_proto_pkg::ip_ttl_t                              tx_ttl,
    output logic [15:0]                                         tx_checksum,
    output udp_proto_pkg::payload_byte_t                        tx_data,
    output logic                                                tx_valid,
    input  logic                                                tx_ready,
    output logic                                                tx_last,
    output logic                                                tx_user,

    // Board status
    output board_io_pkg::led_byte_t                             ledg,
    output board_io_pkg::seg7_t [board_io_pkg::HEX_DIGITS-1:0] hex
);

    import udp_proto_pkg::*;

    logic          hdr_push_valid;
    logic          hdr_push_ready;
    echo_hdr_t     hdr_push;
    echo_hdr_t     hdr_out;
    logic          beat_push_valid;
    logic          beat_push_ready;
    payload_beat_t beat_push;
    payload_beat_t beat_out;

    udp_port_filter #(
        .ECHO_PORT(ECHO_PORT),
        .LOCAL_IP (LOCAL_IP)
    ) u_filter (
        .clk            (clk),
        .rst            (rst),
        .rx_hdr_valid   (rx_hdr_valid),
        .rx_hdr_ready   (rx_hdr_ready),
        .rx_src_ip      (rx_src_ip),
        .rx_dst_ip      (rx_dst_ip),
        .rx_src_port    (rx_src_port),
        .rx_dst_port    (rx_dst_port),
        .rx_length      (rx_length),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_ready       (rx_ready),
        .rx_last        (rx_last),
        .rx_user        (rx_user),
        .hdr_push_valid (hdr_push_valid),
        .hdr_push_ready (hdr_push_ready),
        .hdr_push       (hdr_push),
        .beat_push_valid(beat_push_valid),
        .beat_push_ready(beat_push_ready),
        .beat_push      (beat_push)
    );

    // Response headers, several frames may be queued
    frame_fifo #(
        .item_t(echo_hdr_t),
        .DEPTH (HDR_DEPTH)
    ) u_hdr_fifo (
        .clk      (clk),
        .rst      (rst),
        .in_valid (hdr_push_valid),
        .in_ready (hdr_push_ready),
        .in_item  (hdr_push),
        .out_valid(tx_hdr_valid),
        .out_ready(tx_hdr_ready),
        .out_item (hdr_out)
    );

    frame_fifo #(
        .item_t(payload_beat_t),
        .DEPTH (PAYLOAD_DEPTH)
    ) u_payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .in_valid (beat_push_valid),
        .in_ready (beat_push_ready),
        .in_item  (beat_push),
        .out_valid(tx_valid),
        .out_ready(tx_ready),
        .out_item (beat_out)
    );

    assign tx_src_ip   = hdr_out.src_ip;
    assign tx_dst_ip   = hdr_out.dst_ip;
    assign tx_src_port = hdr_out.src_port;
    assign tx_dst_port = hdr_out.dst_port;
    assign tx_length   = hdr_out.length;
    assign tx_ttl      = hdr_out.ttl;
    assign tx_checksum = hdr_out.checksum;

    assign tx_data = beat_out.data;
    assign tx_last = beat_out.last;
    assign tx_user = beat_out.user;

    // Watches completed transfers only
    echo_status_display #(
        .SEG_ACTIVE_LOW(SEG_ACTIVE_LOW)
    ) u_status (
        .clk        (clk),
        .rst        (rst),
        .tx_hdr_fire(tx_hdr_valid && tx_hdr_ready),
        .tx_dst_ip  (hdr_out.dst_ip),
        .beat_fire  (tx_valid && tx_ready),
        .beat_data  (beat_out.data),
        .beat_last  (beat_out.last),
        .ledg       (ledg),
        .hex        (hex)
    );

endmodule

// ==== testbench/udp_echo_tasks.svh ====
/*
 * Directed tests for the UDP echo engine
 * Reference model of the response header and the digit font
 * Stream drivers, output comparison and status checks
 */

// Active-high hex font with segment a in bit 0
localparam seg7_t FONT [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                                7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

function automatic seg7_t expected_segments(input logic [3:0] nibble);
    return ~FONT[nibble];
endfunction

// Swapped addresses and ports, TTL 64, no checksum
function automatic echo_hdr_t expected_header(input ip_addr_t src_ip, input udp_port_t src_port,
                                              input udp_port_t dst_port, input udp_len_t len);
    echo_hdr_t h;
    h.src_ip   = LOCAL_IP;
    h.dst_ip   = src_ip;
    h.src_port = dst_port;
    h.dst_port = src_port;
    h.length   = len;
    h.ttl      = 8'd64;
    h.checksum = 16'h0000;
    return h;
endfunction

task automatic check_value(input string what, input logic [151:0] got, input logic [151:0] exp);
    check_count++;
    assert (got === exp) else begin
        error_count++;
        $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
endtask

task automatic next_drive_point();
    @(posedge clk);
    #1;
endtask

// Ready sampled mid-cycle for the transfer on the next edge
task automatic wait_accept(input bit is_hdr);
    bit accepted;
    accepted = 1'b0;
    while (!accepted) begin
        @(negedge clk);
        accepted = is_hdr ? rx_hdr_ready : rx_ready;
        if (is_hdr && !accepted) begin
            hdr_stall_seen = 1'b1;
        end
        next_drive_point();
        if (!accepted && release_on_stall) begin
            tx_hdr_ready = 1'b1;
            tx_ready     = 1'b1;
        end
    end
endtask

task automatic send_frame(input ip_addr_t src_ip, input udp_port_t src_port,
                          input udp_port_t dst_port, input int nbytes);
    payload_beat_t beat;
    int            rnd;
    bit            keep;
    keep         = (dst_port == ECHO_PORT);
    rx_src_ip    = src_ip;
    rx_dst_ip    = LOCAL_IP;
    rx_src_port  = src_port;
    rx_dst_port  = dst_port;
    rx_length    = udp_len_t'(nbytes + 8);
    rx_hdr_valid = 1'b1;
    wait_accept(1'b1);
    rx_hdr_valid = 1'b0;
    if (keep) begin
        exp_hdr.push_back(expected_header(src_ip, src_port, dst_port, udp_len_t'(nbytes + 8)));
        last_dst_ip = src_ip;
    end
    for (int i = 0; i < nbytes; i++) begin
        rnd       = $random(seed);
        beat.data = rnd[7:0];
        beat.user = rnd[8];
        beat.last = (i == nbytes - 1);
        rx_data   = beat.data;
        rx_user   = beat.user;
        rx_last   = beat.last;
        rx_valid  = 1'b1;
        wait_accept(1'b0);
        if (keep) begin
            exp_beat.push_back(beat);
            if (i == 0) begin
                last_first_byte = beat.data;
            end
        end
    end
    rx_valid = 1'b0;
    rx_last  = 1'b0;
endtask

task automatic check_status(input string tag);
    check_value({tag, " ledg"}, 152'(ledg), 152'(last_first_byte));
    for (int i = 0; i < HEX_DIGITS; i++) begin
        check_value($sformatf("%s hex[%0d]", tag, i), 152'(hex[i]),
                    152'(expected_segments(last_dst_ip[4*i +: 4])));
    end
endtask

// Waits for the predicted traffic, then allows a few cycles for strays
task automatic compare_outputs(input string tag);
    while (got_hdr.size() < exp_hdr.size() || got_beat.size() < exp_beat.size()) begin
        @(posedge clk);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_value({tag, " header count"}, 152'(got_hdr.size()), 152'(exp_hdr.size()));
    check_value({tag, " beat count"}, 152'(got_beat.size()), 152'(exp_beat.size()));
    for (int i = 0; i < exp_hdr.size() && i < got_hdr.size(); i++) begin
        check_value($sformatf("%s header %0d", tag, i), 152'(got_hdr[i]), 152'(exp_hdr[i]));
    end
    for (int i = 0; i < exp_beat.size() && i < got_beat.size(); i++) begin
        check_value($sformatf("%s beat %0d", tag, i), 152'(got_beat[i]), 152'(exp_beat[i]));
    end
    check_status(tag);
    got_hdr.delete();
    exp_hdr.delete();
    got_beat.delete();
    exp_beat.delete();
    next_drive_point();
endtask

task automatic verify_reset_state();
    @(negedge clk);
    check_value("reset tx_hdr_valid", 152'(tx_hdr_valid), 152'(0));
    check_value("reset tx_valid", 152'(tx_valid), 152'(0));
    check_value("reset rx_hdr_ready", 152'(rx_hdr_ready), 152'(1));
    check_status("reset");
    next_drive_point();
endtask

// Status display checked after every echoed frame
task automatic echo_matching_frames();
    send_frame(32'hc0a80105, 16'd40000, ECHO_PORT, 1);
    compare_outputs("echo 1 byte");
    send_frame(32'hc0a80106, 16'd40001, ECHO_PORT, 40);
    compare_outputs("echo 40 bytes");
    send_frame(32'h0a0b0c0d, 16'd53, ECHO_PORT, 17);
    compare_outputs("echo 17 bytes");
endtask

// A dropped frame ahead of a kept one
task automatic drop_other_port();
    send_frame(32'hc0a80107, 16'd5555, 16'd4321, 6);
    send_frame(32'hc0a80109, 16'd6000, ECHO_PORT, 5);
    compare_outputs("drop");
endtask

// Ten frames against a header FIFO of eight
task automatic hold_back_pressure();
    tx_hdr_ready     = 1'b0;
    tx_ready         = 1'b0;
    hdr_stall_seen   = 1'b0;
    release_on_stall = 1'b1;
    for (int k = 0; k < 10; k++) begin
        send_frame(32'h0a000001 + k, udp_port_t'(2000 + k), ECHO_PORT, 3);
    end
    release_on_stall = 1'b0;
    tx_hdr_ready     = 1'b1;
    tx_ready         = 1'b1;
    check_value("back-pressure header stall", 152'(hdr_stall_seen), 152'(1));
    compare_outputs("back-pressure");
endtask

// ==== testbench/udp_echo_tb.sv ====
/*
 * Testbench for the UDP echo engine
 * Clock, reset, DUT, transmit monitors
 * Cycle limit and closing report
 */
`timescale 1ns/1ps

module udp_echo_tb;

    import udp_proto_pkg::*;
    import board_io_pkg::*;

    localparam udp_port_t ECHO_PORT      = 16'd1234;
    localparam ip_addr_t  LOCAL_IP       = 32'hc0a80180;
    // About 20 frames of up to 40 beats, with margin
    localparam int        TIMEOUT_CYCLES = 4000;

    logic          clk = 1'b0;
    logic          rst;
    logic          rx_hdr_valid;
    logic          rx_hdr_ready;
    ip_addr_t      rx_src_ip;
    ip_addr_t      rx_dst_ip;
    udp_port_t     rx_src_port;
    udp_port_t     rx_dst_port;
    udp_len_t      rx_length;
    payload_byte_t rx_data;
    logic          rx_valid;
    logic          rx_ready;
    logic          rx_last;
    logic          rx_user;
    logic          tx_hdr_valid;
    logic          tx_hdr_ready;
    ip_addr_t      tx_src_ip;
    ip_addr_t      tx_dst_ip;
    udp_port_t     tx_src_port;
    udp_port_t     tx_dst_port;
    udp_len_t      tx_length;
    ip_ttl_t       tx_ttl;
    logic [15:0]   tx_checksum;
    payload_byte_t tx_data;
    logic          tx_valid;
    logic          tx_ready;
    logic          tx_last;
    logic          tx_user;
    led_byte_t     ledg;
    seg7_t [HEX_DIGITS-1:0] hex;

    // Observed and predicted transmit traffic
    echo_hdr_t     got_hdr[$];
    echo_hdr_t     exp_hdr[$];
    payload_beat_t got_beat[$];
    payload_beat_t exp_beat[$];

    // Model of the status display
    payload_byte_t last_first_byte = '0;
    ip_addr_t      last_dst_ip     = '0;

    integer seed             = 75;
    int     cycles           = 0;
    int     check_count      = 0;
    int     error_count      = 0;
    bit     hdr_stall_seen   = 1'b0;
    bit     release_on_stall = 1'b0;

    always #10 clk = ~clk;

    udp_echo_top #(
        .ECHO_PORT     (ECHO_PORT),
        .LOCAL_IP      (LOCAL_IP),
        .HDR_DEPTH     (8),
        .PAYLOAD_DEPTH (64),
        .SEG_ACTIVE_LOW(1'b1)
    ) uut (
        .clk(clk), .rst(rst),
        .rx_hdr_valid(rx_hdr_valid), .rx_hdr_ready(rx_hdr_ready),
        .rx_src_ip(rx_src_ip), .rx_dst_ip(rx_dst_ip),
        .rx_src_port(rx_src_port), .rx_dst_port(rx_dst_port), .rx_length(rx_length),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .rx_last(rx_last), .rx_user(rx_user),
        .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
        .tx_src_ip(tx_src_ip), .tx_dst_ip(tx_dst_ip),
        .tx_src_port(tx_src_port), .tx_dst_port(tx_dst_port), .tx_length(tx_length),
        .tx_ttl(tx_ttl), .tx_checksum(tx_checksum),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .tx_last(tx_last), .tx_user(tx_user),
        .ledg(ledg), .hex(hex)
    );

    `include "udp_echo_tasks.svh"

    // Mid-cycle sampling sees what the next rising edge transfers
    always @(negedge clk) begin
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            got_hdr.push_back({tx_src_ip, tx_dst_ip, tx_src_port, tx_dst_port,
                               tx_length, tx_ttl, tx_checksum});
        end
        if (!rst && tx_valid && tx_ready) begin
            got_beat.push_back({tx_data, tx_last, tx_user});
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks run: %0d, errors: %0d", check_count, error_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_src_ip    = '0;
        rx_dst_ip    = '0;
        rx_src_port  = '0;
        rx_dst_port  = '0;
        rx_length    = '0;
        rx_data      = '0;
        rx_valid     = 1'b0;
        rx_last      = 1'b0;
        rx_user      = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_ready     = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        verify_reset_state();
        echo_matching_frames();
        drop_other_port();
        hold_back_pressure();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+testbench
verilog/udp_proto_pkg.sv
verilog/board_io_pkg.sv
verilog/hex_digit_decoder.sv
verilog/frame_fifo.sv
verilog/udp_port_filter.sv
verilog/echo_status_display.sv
verilog/udp_echo_top.sv
testbench/udp_echo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the UDP echo testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    -f build.f --top-module udp_echo_tb -Mdir obj_dir -o udp_echo_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/udp_echo_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
exit 1
